//--- hdl/music_pkg.sv
/*
  Shared types and constants for the tune player.
  A note record of duration 0 marks the end of a song.
  Note 0 is a rest and plays silence for its duration.
  The half period rule only gives a usable pitch for notes 1 to 63.
*/
`default_nettype none

package music_pkg;

    // One song record as stored in the ROM and carried through the FIFO
    typedef struct packed {
        logic [5:0] note;
        logic [5:0] duration;
    } note_t;

    // Signed audio sample as presented to the codec
    typedef logic signed [15:0] sample_t;

    // Song number, four songs in all
    typedef logic [1:0] song_id_t;

    // Records reserved per song in the ROM
    localparam int SONG_LEN = 16;

    // Square wave level, the output swings between plus and minus this value
    localparam sample_t AMPLITUDE = 16'sd8192;

    // Samples per half period of the square wave for a given note number
    function automatic logic [6:0] half_period(input logic [5:0] note);
        return 7'd64 - {1'b0, note};
    endfunction

endpackage

`default_nettype wire

//--- hdl/song_rom.sv
/*
  Fixed song table with four songs of at most 16 records.
  The read data is registered, so it appears one cycle after the address.
  Unused entries read as the end marker.
*/
`timescale 1ns/100ps
`default_nettype none

module song_rom import music_pkg::*; (
    input  wire                                           clk,
    input  wire [$bits(song_id_t)+$clog2(SONG_LEN)-1:0]   addr,
    output note_t                                         data
);

    // Upper two address bits pick the song, lower four pick the record
    always_ff @(posedge clk) begin
        case (addr)
            // Song 0
            6'h00: data <= '{note: 6'd32, duration: 6'd2};
            6'h01: data <= '{note: 6'd0,  duration: 6'd1};
            6'h02: data <= '{note: 6'd40, duration: 6'd2};
            6'h03: data <= '{note: 6'd48, duration: 6'd1};
            6'h04: data <= '{note: 6'd56, duration: 6'd2};
            6'h05: data <= '{note: 6'd0,  duration: 6'd0};
            // Song 1
            6'h10: data <= '{note: 6'd20, duration: 6'd1};
            6'h11: data <= '{note: 6'd44, duration: 6'd2};
            6'h12: data <= '{note: 6'd0,  duration: 6'd1};
            6'h13: data <= '{note: 6'd52, duration: 6'd1};
            6'h14: data <= '{note: 6'd0,  duration: 6'd0};
            // Song 2
            6'h20: data <= '{note: 6'd16, duration: 6'd3};
            6'h21: data <= '{note: 6'd24, duration: 6'd1};
            6'h22: data <= '{note: 6'd0,  duration: 6'd0};
            // Song 3
            6'h30: data <= '{note: 6'd60, duration: 6'd1};
            6'h31: data <= '{note: 6'd30, duration: 6'd1};
            6'h32: data <= '{note: 6'd45, duration: 6'd2};
            6'h33: data <= '{note: 6'd0,  duration: 6'd0};
            // Anything else behaves as an end marker
            default: data <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/song_reader.sv
/*
  Producer side of the note buffer.
  Reads the current song record by record and pushes each one, the end
  marker included, then idles until the next reset_player pulse.
  Each record costs at least two cycles because of the registered ROM.
  A song without a marker stops after its sixteenth record.
*/
`timescale 1ns/100ps
`default_nettype none

module song_reader import music_pkg::*; (
    input  wire      clk,
    input  wire      arst_n,
    input  wire      reset_player,
    input  wire      full,
    input  song_id_t song,
    output logic     push,
    output note_t    push_data
);

    logic [$clog2(SONG_LEN)-1:0] idx;
    // High when the ROM output holds the record at idx
    logic                        rd_valid;
    // Set once the last record of the song has gone into the FIFO
    logic                        done;
    note_t                       rom_data;

    song_rom song_rom (
        .clk  (clk),
        .addr ({song, idx}),
        .data (rom_data)
    );

    // The address is held while the FIFO is full, so the data stays put too
    assign push      = rd_valid && !done && !full && !reset_player;
    assign push_data = rom_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx      <= '0;
            rd_valid <= 1'b0;
            done     <= 1'b0;
        end else if (reset_player) begin
            idx      <= '0;
            rd_valid <= 1'b0;
            done     <= 1'b0;
        end else if (!done) begin
            if (!rd_valid) begin
                // Address was presented this cycle, data is ready next cycle
                rd_valid <= 1'b1;
            end else if (!full) begin
                // Record is pushed now
                rd_valid <= 1'b0;
                if (rom_data.duration == 6'd0 || idx == SONG_LEN - 1) begin
                    done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/note_fifo.sv
/*
  Single clock FIFO with a payload type parameter.
  pop_data shows the head entry whenever empty is low.
  A push while full and a pop while empty are dropped.
  flush empties the FIFO and wins over a push or a pop in the same cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module note_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 4
) (
    input  wire      clk,
    input  wire      arst_n,
    input  wire      flush,
    input  wire      push,
    input  wire      pop,
    input  payload_t push_data,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            // Occupancy only moves when exactly one side acts
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mcu.sv
/*
  Playback control from the one-pulse buttons.
  Buttons must already be debounced and one cycle long.
  The song counter wraps from song 3 back to song 0.
  Selecting a song does not change the play state.
*/
`timescale 1ns/100ps
`default_nettype none

module mcu import music_pkg::*; (
    input  wire      clk,
    input  wire      arst_n,
    input  wire      play_button,
    input  wire      next_button,
    input  wire      rewind_button,
    input  wire      song_done,
    output logic     play,
    output logic     reset_player,
    output song_id_t song
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            play         <= 1'b0;
            reset_player <= 1'b0;
            song         <= '0;
        end else begin
            // Both next and rewind restart the song from its first record
            reset_player <= next_button || rewind_button;

            // Two bit counter, so song 3 rolls over to song 0
            if (next_button) begin
                song <= song_id_t'(song + 1'b1);
            end

            // End of song has priority over a play press in the same cycle
            if (song_done) begin
                play <= 1'b0;
            end else if (play_button) begin
                play <= !play;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/beat_generator.sv
/*
  Divides the enable pulses down to one beat every BEAT_COUNT of them.
  beat is combinational and coincides with the enable that completes a beat.
*/
`timescale 1ns/100ps
`default_nettype none

module beat_generator #(
    parameter int BEAT_COUNT = 1000
) (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  en,
    output logic beat
);

    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    logic [CNT_W-1:0] count;
    logic             last;

    assign last = (count == CNT_W'(BEAT_COUNT - 1));
    assign beat = en && last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) count <= '0;
        else if (en) count <= last ? '0 : count + 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/note_player.sv
/*
  Consumer side of the note buffer, makes one sample per request.
  sample_ready follows generate_next_sample by one cycle.
  Beats only count while playing with a note loaded, so the beat phase
  carries across notes and is not cleared by reset_player.
  ff ends the loaded note after the sample of the next request.
*/
`timescale 1ns/100ps
`default_nettype none

module note_player import music_pkg::*; (
    input  wire     clk,
    input  wire     arst_n,
    input  wire     play,
    input  wire     reset_player,
    input  wire     ff,
    input  wire     generate_next_sample,
    input  wire     beat,
    input  wire     empty,
    input  note_t   pop_data,
    output logic    pop,
    output logic    sample_ready,
    output logic    song_done,
    output logic    beat_en,
    output sample_t sample
);

    // Loaded note, its duration field counts down the beats left
    note_t      cur;
    logic       have_note;
    logic       ff_pend;
    logic [6:0] phase_cnt;
    // Low for the positive half of the wave
    logic       neg;
    logic [6:0] hp;
    logic       advance;
    logic       note_end;

    assign hp       = half_period(cur.note);
    assign advance  = generate_next_sample && play && have_note;
    assign beat_en  = advance;
    assign note_end = beat && (cur.duration == 6'd1);
    // The FIFO is flushed during reset_player, so no pop then
    assign pop      = !have_note && !empty && !reset_player;

    always_ff @(posedge clk) begin
        if (pop) cur <= pop_data;
        else if (advance && beat) cur.duration <= cur.duration - 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            have_note    <= 1'b0;
            ff_pend      <= 1'b0;
            phase_cnt    <= '0;
            neg          <= 1'b0;
            sample_ready <= 1'b0;
            song_done    <= 1'b0;
            sample       <= '0;
        end else begin
            sample_ready <= generate_next_sample;
            song_done    <= 1'b0;

            // Silence while paused, starved or resting
            if (generate_next_sample) begin
                if (play && have_note && cur.note != 6'd0) sample <= neg ? -AMPLITUDE : AMPLITUDE;
                else sample <= '0;
            end

            if (reset_player) begin
                have_note <= 1'b0;
                ff_pend   <= 1'b0;
            end else if (pop) begin
                // Every note starts on the positive half at phase zero
                phase_cnt <= '0;
                neg       <= 1'b0;
                have_note <= (pop_data.duration != 6'd0);
                song_done <= (pop_data.duration == 6'd0);
                ff_pend   <= 1'b0;
            end else if (advance) begin
                if (phase_cnt + 7'd1 >= hp) begin
                    phase_cnt <= '0;
                    neg       <= !neg;
                end else begin
                    phase_cnt <= phase_cnt + 7'd1;
                end
                if (note_end || ff || ff_pend) have_note <= 1'b0;
                ff_pend <= 1'b0;
            end else if (ff && have_note) begin
                // Held until the next request, also while paused
                ff_pend <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/codec_conditioner.sv
/*
  Synchronises sample hand-off to the codec frame.
  new_frame is taken as already in the clk domain.
  A frame edge in one cycle updates sample_out and requests the next
  sample in the following cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module codec_conditioner import music_pkg::*; (
    input  wire     clk,
    input  wire     arst_n,
    input  wire     new_frame,
    input  wire     sample_ready,
    input  sample_t sample,
    output logic    generate_next_sample,
    output sample_t sample_out
);

    logic    frame_q;
    logic    frame_rise;
    // Sample waiting for the next frame
    sample_t pending;

    assign frame_rise = new_frame && !frame_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_q              <= 1'b0;
            generate_next_sample <= 1'b0;
            sample_out           <= '0;
            pending              <= '0;
        end else begin
            frame_q              <= new_frame;
            generate_next_sample <= frame_rise;
            if (frame_rise) sample_out <= pending;
            // The player answers well before the next frame edge
            if (sample_ready) pending <= sample;
        end
    end

endmodule

`default_nettype wire

//--- hdl/music_player.sv
/*
  Top level of the tune player.
  Buttons must be debounced one-cycle pulses in the clk domain.
  new_sample_generated pulses once per new_frame rising edge, one cycle
  after the edge, together with the updated sample_out.
  BEAT_COUNT can be lowered to shorten simulations.
*/
`timescale 1ns/100ps
`default_nettype none

module music_player import music_pkg::*; #(
    parameter int BEAT_COUNT = 1000,
    parameter int FIFO_DEPTH = 4
) (
    input  wire     clk,
    input  wire     arst_n,
    input  wire     play_button,
    input  wire     next_button,
    input  wire     rewind_button,
    input  wire     ff_button,
    input  wire     new_frame,
    output logic    new_sample_generated,
    output sample_t sample_out
);

    logic     play;
    logic     reset_player;
    song_id_t song;
    logic     song_done;
    logic     push;
    note_t    push_data;
    logic     full;
    logic     empty;
    logic     pop;
    note_t    pop_data;
    logic     beat_en;
    logic     beat;
    logic     sample_ready;
    sample_t  sample;

    mcu mcu (
        .clk           (clk),
        .arst_n        (arst_n),
        .play_button   (play_button),
        .next_button   (next_button),
        .rewind_button (rewind_button),
        .song_done     (song_done),
        .play          (play),
        .reset_player  (reset_player),
        .song          (song)
    );

    song_reader song_reader (
        .clk          (clk),
        .arst_n       (arst_n),
        .reset_player (reset_player),
        .full         (full),
        .song         (song),
        .push         (push),
        .push_data    (push_data)
    );

    // reset_player also drops any notes already buffered
    note_fifo #(.payload_t(note_t), .FIFO_DEPTH(FIFO_DEPTH)) note_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (reset_player),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    beat_generator #(.BEAT_COUNT(BEAT_COUNT)) beat_generator (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (beat_en),
        .beat   (beat)
    );

    note_player note_player (
        .clk                  (clk),
        .arst_n               (arst_n),
        .play                 (play),
        .reset_player         (reset_player),
        .ff                   (ff_button),
        .generate_next_sample (new_sample_generated),
        .beat                 (beat),
        .empty                (empty),
        .pop_data             (pop_data),
        .pop                  (pop),
        .sample_ready         (sample_ready),
        .song_done            (song_done),
        .beat_en              (beat_en),
        .sample               (sample)
    );

    // The sample request doubles as the new sample strobe
    codec_conditioner codec_conditioner (
        .clk                  (clk),
        .arst_n               (arst_n),
        .new_frame            (new_frame),
        .sample_ready         (sample_ready),
        .sample               (sample),
        .generate_next_sample (new_sample_generated),
        .sample_out           (sample_out)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/*
  Free running testbench clock, 4 ns period.
  arst_n is held low for the first 3 rising edges and released on a falling edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = !clk;
    end

    // Release away from the rising edge so the DUT leaves reset cleanly
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/music_player_tb.sv
/*
  Trace-driven testbench for the tune player, DUT built with BEAT_COUNT 8.
  Song contents and button commands come from dv/music_trace.txt, so the
  simulation must be started from the project root.
  new_frame is high in cycles 0 and 1 of each 8-cycle frame, and buttons
  are pulsed in cycle 3. sample_out lags the model's sample by one frame.
  The run stops at the first mismatch.
*/
`timescale 1ns/100ps
`default_nettype none

module music_player_tb import music_pkg::*; ();

    localparam int BEAT_COUNT    = 8;
    localparam int FIFO_DEPTH    = 4;
    localparam int FRAME_CYCLES  = 8;
    localparam int PRESS_CYCLE   = 3;
    localparam int MARGIN_CYCLES = 200;

    logic        clk;
    logic        arst_n;
    logic        play_button;
    logic        next_button;
    logic        rewind_button;
    logic        ff_button;
    logic        new_frame;
    logic        new_sample_generated;
    sample_t     sample_out;

    // Song records and commands as read from the trace
    int          rec_note [4][SONG_LEN];
    int          rec_dur  [4][SONG_LEN];
    logic [63:0] cmd_button [$];
    int          cmd_wait   [$];
    int          total_frames;
    int          cycle_limit = MARGIN_CYCLES;
    int          cycle_count = 0;
    int          frame_no;

    // Reference model state, mirrors what the player holds between requests
    int          mdl_song;
    int          mdl_idx;
    int          mdl_note;
    int          mdl_rem;
    int          mdl_phase;
    int          mdl_beat_cnt;
    int          mdl_pending;
    bit          mdl_play;
    bit          mdl_have;
    bit          mdl_neg;
    bit          mdl_ff_pend;
    // Set in a frame whose request popped the end marker
    bit          mdl_ended;

    tb_clock clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    music_player #(.BEAT_COUNT(BEAT_COUNT), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk                  (clk),
        .arst_n               (arst_n),
        .play_button          (play_button),
        .next_button          (next_button),
        .rewind_button        (rewind_button),
        .ff_button            (ff_button),
        .new_frame            (new_frame),
        .new_sample_generated (new_sample_generated),
        .sample_out           (sample_out)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            $display("error: %s expected %0d actual %0d", test_name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "first mismatch");
        end
    endtask

    // Cycle budget follows the frame count of the trace
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("timeout: run still going after %0d cycles", cycle_limit));
        end
    end

    task automatic read_trace();
        int               fd;
        int               n;
        int               sid;
        int               nt;
        int               du;
        int               k;
        int               wait_frames;
        bit               done;
        logic [63:0]      tag;
        logic [63:0]      name;
        logic [8*256-1:0] rest;
        total_frames = 0;
        fd = $fopen("dv/music_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the trace file dv/music_trace.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if (tag == "S") begin
                    // Pairs of note and duration up to the end marker
                    n = $fscanf(fd, "%d", sid);
                    k = 0;
                    du = 1;
                    while (du != 0) begin
                        n = $fscanf(fd, "%d %d", nt, du);
                        if (n != 2 || sid < 0 || sid > 3 || k >= SONG_LEN) begin
                            stop_with_failure("a song line in the trace file is malformed");
                        end else begin
                            rec_note[sid][k] = nt;
                            rec_dur[sid][k]  = du;
                            k++;
                        end
                    end
                end else if (tag == "C") begin
                    n = $fscanf(fd, "%s %d", name, wait_frames);
                    if (n != 2 || !(name == "play" || name == "next" || name == "rewind" ||
                                    name == "ff" || name == "idle")) begin
                        stop_with_failure("a command line in the trace file is malformed");
                    end else begin
                        cmd_button.push_back(name);
                        cmd_wait.push_back(wait_frames);
                        total_frames += wait_frames + 1;
                    end
                end else begin
                    stop_with_failure("the trace file holds a line of unknown type");
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int wave_half_period(input int note);
        return 64 - note;
    endfunction

    // The player pops the next record of the current song
    task automatic load_record();
        mdl_ff_pend = 1'b0;
        if (rec_dur[mdl_song][mdl_idx] == 0) begin
            // End marker, the control unit drops play right after
            mdl_have  = 1'b0;
            mdl_play  = 1'b0;
            mdl_ended = 1'b1;
        end else begin
            mdl_note  = rec_note[mdl_song][mdl_idx];
            mdl_rem   = rec_dur[mdl_song][mdl_idx];
            mdl_phase = 0;
            mdl_neg   = 1'b0;
            mdl_have  = 1'b1;
            mdl_idx++;
        end
    endtask

    task automatic restart_song();
        mdl_idx = 0;
        load_record();
    endtask

    task automatic reset_model();
        mdl_song     = 0;
        mdl_play     = 1'b0;
        mdl_beat_cnt = 0;
        mdl_pending  = 0;
        mdl_ended    = 1'b0;
        restart_song();
    endtask

    // One sample request, the sample comes from the state before the update
    task automatic predict_sample(output int value);
        bit beat;
        bit ending;
        value = 0;
        if (mdl_play && mdl_have) begin
            if (mdl_note != 0) value = mdl_neg ? -int'(AMPLITUDE) : int'(AMPLITUDE);
            if (mdl_phase + 1 >= wave_half_period(mdl_note)) begin
                mdl_phase = 0;
                mdl_neg   = !mdl_neg;
            end else begin
                mdl_phase++;
            end
            // Beat phase runs on across notes and restarts
            beat = (mdl_beat_cnt == BEAT_COUNT - 1);
            mdl_beat_cnt = beat ? 0 : mdl_beat_cnt + 1;
            ending = mdl_ff_pend;
            if (beat) begin
                if (mdl_rem == 1) ending = 1'b1;
                mdl_rem--;
            end
            mdl_ff_pend = 1'b0;
            if (ending) load_record();
        end
    endtask

    task automatic apply_button(input logic [63:0] button);
        if (button == "play") begin
            // A song end in the same frame wins over the press
            if (!mdl_ended) mdl_play = !mdl_play;
        end else if (button == "next") begin
            mdl_song = (mdl_song + 1) % 4;
            restart_song();
        end else if (button == "rewind") begin
            restart_song();
        end else if (button == "ff") begin
            if (mdl_have) mdl_ff_pend = 1'b1;
        end
    endtask

    // Outputs are checked on the falling edge, before the inputs change
    task automatic run_frame(input logic [63:0] button);
        int value;
        for (int p = 0; p < FRAME_CYCLES; p++) begin
            @(negedge clk);
            check($sformatf("strobe, frame %0d cycle %0d", frame_no, p),
                  (p == 1) ? 1 : 0, int'(new_sample_generated));
            if (p == 1) begin
                check($sformatf("sample, frame %0d", frame_no), mdl_pending, int'(sample_out));
                mdl_ended = 1'b0;
                predict_sample(value);
                mdl_pending = value;
            end
            new_frame = (p < 2);
            if (p == PRESS_CYCLE) begin
                play_button   = (button == "play");
                next_button   = (button == "next");
                rewind_button = (button == "rewind");
                ff_button     = (button == "ff");
                apply_button(button);
            end else if (p == PRESS_CYCLE + 1) begin
                play_button   = 1'b0;
                next_button   = 1'b0;
                rewind_button = 1'b0;
                ff_button     = 1'b0;
            end
        end
        frame_no++;
    endtask

    initial begin
        play_button   = 1'b0;
        next_button   = 1'b0;
        rewind_button = 1'b0;
        ff_button     = 1'b0;
        new_frame     = 1'b0;
        frame_no      = 0;
        read_trace();
        cycle_limit = FRAME_CYCLES * total_frames + MARGIN_CYCLES;
        reset_model();
        wait (arst_n === 1'b1);
        // Gives the reader time to hand the first record to the player
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            check("strobe before the first frame", 0, int'(new_sample_generated));
            check("sample before the first frame", 0, int'(sample_out));
        end
        foreach (cmd_wait[i]) begin
            repeat (cmd_wait[i]) run_frame("idle");
            run_frame(cmd_button[i]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/music_trace.txt
# S <song> then note and duration pairs, up to and including the 0 0 end marker
# C <button> <frames to wait before the press>, the button idle presses nothing
S 0 32 2 0 1 40 2 48 1 56 2 0 0
S 1 20 1 44 2 0 1 52 1 0 0
S 2 16 3 24 1 0 0
S 3 60 1 30 1 45 2 0 0
C play 4
C play 20
C play 5
C ff 6
C rewind 4
C next 10
C idle 60
C play 2
C idle 4

//--- src.f
hdl/music_pkg.sv
hdl/song_rom.sv
hdl/song_reader.sv
hdl/note_fifo.sv
hdl/mcu.sv
hdl/beat_generator.sv
hdl/note_player.sv
hdl/codec_conditioner.sv
hdl/music_player.sv
dv/tb_clock.sv
dv/music_player_tb.sv

//--- Makefile
# Verilator build, run and lint for the tune player testbench

VERILATOR ?= verilator
TOP       ?= music_player_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q -F '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
